// File: tests/display_patterns.txt
# C op x y colour : draw command, op 0 plot or 1 clear, buffer x y decimal, colour hex {b,g,r}
# E sx sy colour : screen pixel expected in the next frame, F captures and checks one frame
C 0 0 0 00f
C 0 3 2 0f0
C 0 15 11 f00
C 0 7 5 a5c
# Out of range plots, the first would alias onto buffer pixel 0,5
C 0 16 4 fff
C 0 2 12 fff
C 0 200 3 fff
E 0 0 00f
E 1 1 00f
E 6 4 0f0
E 7 5 0f0
E 31 23 f00
E 15 11 a5c
E 0 10 000
E 2 0 000
F
# Clear, then a plot offered at once
C 1 0 0 123
C 0 4 4 abc
E 0 0 123
E 8 8 abc
E 9 9 abc
E 10 8 123
E 31 23 123
F

// File: flist.f
hdl/video_modes_pkg.sv
hdl/pixel_writer.sv
hdl/frame_buffer.sv
hdl/display.sv
hdl/video_top.sv
tests/tb_video_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the video_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_video_top -f flist.f -o sim_video

# The log decides the result, so a nonzero simulator exit is not fatal here
./obj_dir/sim_video > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tests/tb_video_top.sv
// ************************************************
// video_top testbench
// ************************************************

`timescale 1ns/1ps

module tb_video_top;
    import video_modes_pkg::*;

    localparam video_mode_t MODE = VMODE_TEST;
    localparam int BUF_W = 16;
    localparam int BUF_H = 12;
    localparam int SCALE = 2;
    localparam int VIS_W = BUF_W * SCALE;
    localparam int VIS_H = BUF_H * SCALE;
    localparam int LINE = int'(MODE.h_resolution) + int'(MODE.h_front_porch)
                        + int'(MODE.h_sync) + int'(MODE.h_back_porch);
    localparam int FRAME = int'(MODE.v_resolution) + int'(MODE.v_front_porch)
                         + int'(MODE.v_sync) + int'(MODE.v_back_porch);
    localparam int TIMEOUT = 4 * LINE * FRAME;

    logic       clk_pixel;
    logic       rstn_pixel;
    draw_cmd_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;

    // Reference image of the buffer and one captured screen
    logic [11:0] model [BUF_H][BUF_W];
    logic [11:0] screen [VIS_H][VIS_W];
    int          exp_x[$];
    int          exp_y[$];
    logic [11:0] exp_col[$];

    int          errors = 0;
    logic [31:0] lcg_state = 32'h8426;
    bit          after_clear = 0;
    bit          clear_checked = 0;
    bit          capture_req = 0;
    bit          capture_on = 0;
    bit          capture_done = 0;

    // Raster tracking from the sync outputs
    bit          h_act, v_act, h_act_q, v_act_q, h_seen, v_seen, pos_valid;
    int          h_since, v_since, h_len, v_len, hcount, vline, sx, sy;
    int          v_checks = 0;
    logic [11:0] colour;

    video_top #(
        .VIDEO_MODE    (VMODE_TEST),
        .BUFFER_WIDTH  (BUF_W),
        .BUFFER_HEIGHT (BUF_H)
    ) u_dut (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

    initial clk_pixel = 1'b0;
    always #20 clk_pixel = ~clk_pixel;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("Error: %s", what);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_idle(input string name);
        check_value({name, " cmd_ready"}, 1, cmd_ready);
        check_value({name, " colour"}, 0, {vga_blue, vga_green, vga_red});
        check_value({name, " hsync"}, !MODE.h_sync_pol, vga_hsync);
        check_value({name, " vsync"}, !MODE.v_sync_pol, vga_vsync);
    endtask

    // Offer one command and count the cycles it waits for cmd_ready
    task automatic send_cmd(input draw_cmd_t c, output int stall);
        cmd = c;
        cmd_valid = 1'b1;
        stall = 0;
        @(negedge clk_pixel);
        while (!cmd_ready) begin
            stall++;
            if (stall > TIMEOUT) stop_with_error("cmd_ready stayed low");
            @(negedge clk_pixel);
        end
        @(posedge clk_pixel);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic run_command(input draw_cmd_t c);
        int stall;
        int gap;
        // A command right after a clear goes out at once to see the back-pressure
        if (!after_clear) begin
            gap = int'(next_rand() >> 16) % 4;
            repeat (gap) begin
                @(posedge clk_pixel);
                #1;
            end
        end
        send_cmd(c, stall);
        if (after_clear) begin
            check_value("clear back-pressure cycles", BUF_W * BUF_H, stall);
            clear_checked = 1;
        end else begin
            // Outside a clear the writer never stalls the client
            check_value("command stall cycles", 0, stall);
        end
        after_clear = (c.op == op_clear);
        if (c.op == op_clear) begin
            foreach (model[i, j]) model[i][j] = c.color;
        end else if (c.x < BUF_W && c.y < BUF_H) begin
            model[c.y][c.x] = c.color;
        end
    endtask

    task automatic capture_frame();
        int waited;
        capture_done = 0;
        capture_req = 1;
        waited = 0;
        while (!capture_done) begin
            @(posedge clk_pixel);
            waited++;
            if (waited > TIMEOUT) stop_with_error("no complete frame seen on the sync outputs");
        end
    endtask

    task automatic check_frame();
        int x;
        int y;
        for (y = 0; y < VIS_H; y++) begin
            for (x = 0; x < VIS_W; x++) begin
                check_value($sformatf("frame %0d,%0d", x, y),
                            model[y / SCALE][x / SCALE], screen[y][x]);
            end
        end
        while (exp_x.size() > 0) begin
            x = exp_x.pop_front();
            y = exp_y.pop_front();
            check_value($sformatf("pixel %0d,%0d", x, y), exp_col.pop_front(), screen[y][x]);
        end
    endtask

    // Sync timing, screen position, blanking and capture
    always @(negedge clk_pixel) begin
        if (rstn_pixel) begin
            h_act = (vga_hsync == MODE.h_sync_pol);
            v_act = (vga_vsync == MODE.v_sync_pol);
            colour = {vga_blue, vga_green, vga_red};
            h_since++;
            v_since++;
            hcount++;
            if (h_act) h_len++;
            if (v_act) v_len++;
            if (h_act && !h_act_q) begin
                if (h_seen) check_value("hsync period", LINE, h_since);
                h_seen = 1;
                h_since = 0;
            end
            // End of hsync, back porch follows
            if (!h_act && h_act_q) begin
                check_value("hsync width", int'(MODE.h_sync), h_len);
                h_len = 0;
                hcount = 0;
                vline++;
            end
            if (v_act && !v_act_q) begin
                if (v_seen) begin
                    check_value("vsync period", LINE * FRAME, v_since);
                    v_checks++;
                end
                v_seen = 1;
                v_since = 0;
            end
            // Frame boundary
            if (!v_act && v_act_q) begin
                check_value("vsync width", int'(MODE.v_sync) * LINE, v_len);
                v_len = 0;
                vline = 0;
                pos_valid = 1;
                if (capture_on) begin
                    capture_on = 0;
                    capture_done = 1;
                end else if (capture_req) begin
                    capture_req = 0;
                    capture_on = 1;
                end
            end
            sx = hcount - int'(MODE.h_back_porch);
            sy = vline - int'(MODE.v_back_porch);
            if (pos_valid && sx >= 0 && sx < VIS_W && sy >= 0 && sy < VIS_H) begin
                if (capture_on) screen[sy][sx] = colour;
            end else if (pos_valid) begin
                check_value("blanking", 0, colour);
            end
            h_act_q = h_act;
            v_act_q = v_act;
        end
    end

    int               fd;
    int               n;
    int               op, px, py;
    logic [11:0]      col;
    logic [8*8-1:0]   tag;
    logic [8*128-1:0] rest;
    draw_cmd_t        cur_cmd;

    initial begin
        cmd = '0;
        cmd_valid = 1'b0;
        rstn_pixel = 1'b0;
        foreach (model[i, j]) model[i][j] = '0;
        repeat (3) @(posedge clk_pixel);
        check_idle("during reset");
        #1;
        rstn_pixel = 1'b1;
        // First clock edge out of reset must keep the idle outputs
        @(posedge clk_pixel);
        @(negedge clk_pixel);
        check_idle("after reset");
        @(posedge clk_pixel);
        #1;

        fd = $fopen("tests/display_patterns.txt", "r");
        if (fd == 0) stop_with_error("cannot open tests/display_patterns.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "C") begin
                n = $fscanf(fd, "%d %d %d %h", op, px, py, col);
                if (n != 4) stop_with_error("malformed command line in pattern file");
                cur_cmd.op = (op != 0) ? op_clear : op_plot;
                cur_cmd.x = COORD_X_W'(px);
                cur_cmd.y = COORD_Y_W'(py);
                cur_cmd.color = col;
                run_command(cur_cmd);
            end else if (tag == "E") begin
                n = $fscanf(fd, "%d %d %h", px, py, col);
                if (n != 3) stop_with_error("malformed expect line in pattern file");
                exp_x.push_back(px);
                exp_y.push_back(py);
                exp_col.push_back(col);
            end else if (tag == "F") begin
                capture_frame();
                check_frame();
            end else begin
                stop_with_error("unknown line type in pattern file");
            end
        end
        $fclose(fd);

        if (v_checks < 2) stop_with_error("fewer than two full frames of sync were checked");
        if (!clear_checked) stop_with_error("no clear was followed by a command");
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: hdl/video_top.sv
// ************************************************
// VGA scan-out subsystem top
// ************************************************

`timescale 1ns/1ps

module video_top #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60,
    parameter int BUFFER_WIDTH = 160,
    parameter int BUFFER_HEIGHT = 120
)(
    input  logic                        clk_pixel,
    input  logic                        rstn_pixel,

    // Drawing client
    input  video_modes_pkg::draw_cmd_t  cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,

    // VGA connector
    output logic                        vga_hsync,
    output logic                        vga_vsync,
    output logic [3:0]                  vga_red,
    output logic [3:0]                  vga_green,
    output logic [3:0]                  vga_blue
);
    import video_modes_pkg::*;

    localparam int DEPTH = BUFFER_WIDTH * BUFFER_HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_data;
    logic [ADDR_W-1:0] read_addr;
    pixel_t            read_data;

    pixel_writer #(
        .BUFFER_WIDTH  (BUFFER_WIDTH),
        .BUFFER_HEIGHT (BUFFER_HEIGHT)
    ) u_pixel_writer (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    frame_buffer #(
        .DEPTH (DEPTH)
    ) u_frame_buffer (
        .clk_pixel (clk_pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    display #(
        .VIDEO_MODE    (VIDEO_MODE),
        .BUFFER_WIDTH  (BUFFER_WIDTH),
        .BUFFER_HEIGHT (BUFFER_HEIGHT)
    ) u_display (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

endmodule

// File: hdl/display.sv
// ************************************************
// VGA raster scan-out with upscaling
// ************************************************

`timescale 1ns/1ps

module display #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60,
    parameter int BUFFER_WIDTH = 160,
    parameter int BUFFER_HEIGHT = 120,
    localparam int ADDR_W = $clog2(BUFFER_WIDTH * BUFFER_HEIGHT)
)(
    input  logic                     clk_pixel,
    input  logic                     rstn_pixel,

    output logic [ADDR_W-1:0]        read_addr,
    input  video_modes_pkg::pixel_t  read_data,

    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic [3:0]               vga_red,
    output logic [3:0]               vga_green,
    output logic [3:0]               vga_blue
);
    import video_modes_pkg::*;

    localparam int H_RES = int'(VIDEO_MODE.h_resolution);
    localparam int H_FP = int'(VIDEO_MODE.h_front_porch);
    localparam int H_SYNC = int'(VIDEO_MODE.h_sync);
    localparam int H_BP = int'(VIDEO_MODE.h_back_porch);
    localparam int LINEWIDTH = H_RES + H_FP + H_SYNC + H_BP;

    localparam int V_RES = int'(VIDEO_MODE.v_resolution);
    localparam int V_FP = int'(VIDEO_MODE.v_front_porch);
    localparam int V_SYNC = int'(VIDEO_MODE.v_sync);
    localparam int V_BP = int'(VIDEO_MODE.v_back_porch);
    localparam int LINEHEIGHT = V_RES + V_FP + V_SYNC + V_BP;

    localparam int VW = $clog2(LINEWIDTH);
    localparam int VH = $clog2(LINEHEIGHT);

    // Screen pixels per buffer pixel, as a shift
    localparam int SCALE = $clog2(H_RES / BUFFER_WIDTH);

    // Sync and blanking as they travel down the pipeline
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } raster_ctl_t;

    localparam raster_ctl_t CTL_IDLE = '{
        hsync: !VIDEO_MODE.h_sync_pol,
        vsync: !VIDEO_MODE.v_sync_pol,
        de:    1'b0
    };

    logic [VW-1:0] x;
    logic [VH-1:0] y;

    raster_ctl_t ctl_now;
    raster_ctl_t ctl_d1;
    raster_ctl_t ctl_d2;
    pixel_t      pix_d2;

    logic hsync_active;
    logic vsync_active;

    // Raster counters, free running
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            x <= '0;
            y <= '0;
        end else if (x == VW'(LINEWIDTH - 1)) begin
            x <= '0;
            if (y == VH'(LINEHEIGHT - 1)) begin
                y <= '0;
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // Sync windows follow the front porch
    always_comb begin
        hsync_active = (x >= VW'(H_RES + H_FP)) && (x < VW'(H_RES + H_FP + H_SYNC));
        vsync_active = (y >= VH'(V_RES + V_FP)) && (y < VH'(V_RES + V_FP + V_SYNC));

        ctl_now.hsync = VIDEO_MODE.h_sync_pol ? hsync_active : !hsync_active;
        ctl_now.vsync = VIDEO_MODE.v_sync_pol ? vsync_active : !vsync_active;
        ctl_now.de = (x < VW'(H_RES)) && (y < VH'(V_RES));
    end

    // Scaled buffer address, parked at 0 during blanking
    always_comb begin
        if (ctl_now.de) begin
            read_addr = ADDR_W'(int'(y >> SCALE) * BUFFER_WIDTH + int'(x >> SCALE));
        end else begin
            read_addr = '0;
        end
    end

    // Stages 1 and 2, control delayed to match the RAM read
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            ctl_d1 <= CTL_IDLE;
            ctl_d2 <= CTL_IDLE;
        end else begin
            ctl_d1 <= ctl_now;
            ctl_d2 <= ctl_d1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        pix_d2 <= read_data;
    end

    // Stage 3, output register with blanking
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            vga_hsync <= CTL_IDLE.hsync;
            vga_vsync <= CTL_IDLE.vsync;
            vga_red <= 4'h0;
            vga_green <= 4'h0;
            vga_blue <= 4'h0;
        end else begin
            vga_hsync <= ctl_d2.hsync;
            vga_vsync <= ctl_d2.vsync;
            vga_red <= ctl_d2.de ? pix_d2.red : 4'h0;
            vga_green <= ctl_d2.de ? pix_d2.green : 4'h0;
            vga_blue <= ctl_d2.de ? pix_d2.blue : 4'h0;
        end
    end

    // Horizontal upscale must be an exact power of two
    assert property (@(posedge clk_pixel)
        (H_RES % BUFFER_WIDTH == 0) && ((1 << SCALE) == H_RES / BUFFER_WIDTH))
    else $error("display: width ratio %0d is not a power of two", H_RES / BUFFER_WIDTH);

    // Square pixels, same factor on both axes
    assert property (@(posedge clk_pixel)
        (V_RES % BUFFER_HEIGHT == 0) && (V_RES / BUFFER_HEIGHT == H_RES / BUFFER_WIDTH))
    else $error("display: height ratio does not match width ratio");

endmodule

// File: hdl/frame_buffer.sv
// ************************************************
// Dual-port pixel frame buffer
// ************************************************

`timescale 1ns/1ps

module frame_buffer #(
    parameter int DEPTH = 19200,
    localparam int ADDR_W = $clog2(DEPTH)
)(
    input  logic                     clk_pixel,

    // Write port from the pixel writer
    input  logic                     wr_en,
    input  logic [ADDR_W-1:0]        wr_addr,
    input  video_modes_pkg::pixel_t  wr_data,

    // Read port from the display, one cycle latency
    input  logic [ADDR_W-1:0]        read_addr,
    output video_modes_pkg::pixel_t  read_data
);
    import video_modes_pkg::*;

    pixel_t mem [DEPTH];

    // Start black
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read for block RAM inference
    always_ff @(posedge clk_pixel) begin
        read_data <= mem[read_addr];
    end

    // The display must clamp its scan address to the buffer
    assert property (@(posedge clk_pixel) int'(read_addr) < DEPTH)
    else $error("frame_buffer: read address %0d out of range", read_addr);

endmodule

// File: hdl/pixel_writer.sv
// ************************************************
// Draw command to frame buffer writer
// ************************************************

`timescale 1ns/1ps

module pixel_writer #(
    parameter int BUFFER_WIDTH = 160,
    parameter int BUFFER_HEIGHT = 120,
    localparam int ADDR_W = $clog2(BUFFER_WIDTH * BUFFER_HEIGHT)
)(
    input  logic                        clk_pixel,
    input  logic                        rstn_pixel,

    input  video_modes_pkg::draw_cmd_t  cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,

    output logic                        wr_en,
    output logic [ADDR_W-1:0]           wr_addr,
    output video_modes_pkg::pixel_t     wr_data
);
    import video_modes_pkg::*;

    localparam int PIXEL_COUNT = BUFFER_WIDTH * BUFFER_HEIGHT;

    // High while a clear sweeps the buffer
    logic clearing;

    logic              cmd_accept;
    logic              is_clear;
    logic              plot_in_range;
    logic [ADDR_W-1:0] plot_addr;
    logic              clear_last;

    // Ready drops for the whole clear sweep
    assign cmd_ready = !clearing;

    always_comb begin
        cmd_accept = cmd_valid && cmd_ready;
        is_clear = (cmd.op == op_clear);
        plot_in_range = (int'(cmd.x) < BUFFER_WIDTH) && (int'(cmd.y) < BUFFER_HEIGHT);
        // Row-major linear address
        plot_addr = ADDR_W'(int'(cmd.y) * BUFFER_WIDTH + int'(cmd.x));
        clear_last = (wr_addr == ADDR_W'(PIXEL_COUNT - 1));
    end

    // Control state
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            clearing <= 1'b0;
            wr_en <= 1'b0;
        end else if (clearing) begin
            clearing <= !clear_last;
            wr_en <= !clear_last;
        end else if (cmd_accept) begin
            clearing <= is_clear;
            // Out-of-range plots are swallowed here
            wr_en <= is_clear || plot_in_range;
        end else begin
            wr_en <= 1'b0;
        end
    end

    // Address counter and held colour
    always_ff @(posedge clk_pixel) begin
        if (clearing) begin
            if (!clear_last) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end else if (cmd_accept) begin
            wr_addr <= is_clear ? '0 : plot_addr;
            wr_data <= cmd.color;
        end
    end

    // Every write must land inside the frame buffer
    assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        wr_en |-> (int'(wr_addr) < PIXEL_COUNT))
    else $error("pixel_writer: write address %0d out of range", wr_addr);

endmodule

// File: hdl/video_modes_pkg.sv
// ************************************************
// Video modes and draw command types
// ************************************************

package video_modes_pkg;

    // Timing of one video mode, counted in pixel clocks and lines
    typedef struct packed {
        logic [15:0] h_resolution;
        logic [15:0] h_front_porch;
        logic [15:0] h_sync;
        logic [15:0] h_back_porch;
        logic [15:0] v_resolution;
        logic [15:0] v_front_porch;
        logic [15:0] v_sync;
        logic [15:0] v_back_porch;
        // 1 means the sync pulse is active high
        logic        h_sync_pol;
        logic        v_sync_pol;
    } video_mode_t;

    // Standard VGA, 25.175 MHz pixel clock
    localparam video_mode_t VMODE_640x480p60 = '{
        h_resolution:  16'd640,
        h_front_porch: 16'd16,
        h_sync:        16'd96,
        h_back_porch:  16'd48,
        v_resolution:  16'd480,
        v_front_porch: 16'd10,
        v_sync:        16'd2,
        v_back_porch:  16'd33,
        h_sync_pol:    1'b0,
        v_sync_pol:    1'b0
    };

    // Small mode for simulation, 40 clocks per line and 28 lines per frame
    localparam video_mode_t VMODE_TEST = '{
        h_resolution:  16'd32,
        h_front_porch: 16'd2,
        h_sync:        16'd4,
        h_back_porch:  16'd2,
        v_resolution:  16'd24,
        v_front_porch: 16'd1,
        v_sync:        16'd2,
        v_back_porch:  16'd1,
        h_sync_pol:    1'b1,
        v_sync_pol:    1'b0
    };

    // Buffer coordinate widths
    localparam int COORD_X_W = 8;
    localparam int COORD_Y_W = 7;

    // 12-bit colour, red in the low nibble
    typedef struct packed {
        logic [3:0] blue;
        logic [3:0] green;
        logic [3:0] red;
    } pixel_t;

    typedef enum logic [0:0] {
        op_plot  = 1'b0,
        op_clear = 1'b1
    } draw_op_t;

    // x and y are ignored by a clear
    typedef struct packed {
        draw_op_t               op;
        logic [COORD_X_W-1:0]   x;
        logic [COORD_Y_W-1:0]   y;
        pixel_t                 color;
    } draw_cmd_t;

endpackage
